//--- files.f
src/csr_pkg.sv
src/pipe_reg.sv
src/csr_decode.sv
src/csr_file.sv
src/csr_pipe.sv
src/csr_result.sv
src/csr_unit.sv
dv/csr_unit_assert.sv
dv/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - src/csr_pkg.sv
  - src/pipe_reg.sv
  - src/csr_decode.sv
  - src/csr_file.sv
  - src/csr_pipe.sv
  - src/csr_result.sv
  - src/csr_unit.sv
  - target: dv
    files:
      - dv/csr_unit_assert.sv
      - dv/csr_unit_tb.sv

//--- dv/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    import csr_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSTR    = 32 + 24 + 24 + 6 + 40 + 8;
    localparam logic [6:0]  SYSTEM_OPCODE = 7'b1110011;
    localparam logic [11:0] RO_ADDR [4] = '{CSR_LTID, CSR_GTID, CSR_WARP_ID, CSR_CORE_ID};

    typedef struct packed {
        csr_wb_t wb;
        logic    is_cycle; // counter value unknown, only its growth is checked
    } expect_t;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic [NUM_THREADS-1:0] instr_valid;
    logic [NW_BITS-1:0]     instr_warp;
    logic [31:0]            instr;
    logic [DATA_BITS-1:0]   rs1_data;
    logic                   no_slot;
    logic                   retire;
    logic                   stall;
    csr_wb_t                wb_out;

    integer               seed = 32'h3df8;
    expect_t              exp_q[$];
    logic [DATA_BITS-1:0] model [NUM_WARPS][NUM_SCRATCH];
    logic [DATA_BITS-1:0] last_cycle = '0;
    int                   retire_count = 0;
    bit                   bp_on = 1'b0;
    logic                 csr_pending = 1'b0; // a CSR request sits in the decode register

    csr_unit dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr_warp  (instr_warp),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .no_slot     (no_slot),
        .retire      (retire),
        .stall       (stall),
        .wb_out      (wb_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] csr_instr(input logic [11:0] addr, input logic [4:0] rs1,
                                              input logic [2:0] funct3, input logic [4:0] rd);
        return {addr, rs1, funct3, rd, SYSTEM_OPCODE};
    endfunction

    // SYSTEM opcode with one of the six CSR forms of funct3
    function automatic logic is_csr_word(input logic [31:0] word);
        return (word[6:0] == SYSTEM_OPCODE) && (word[13:12] != 2'b00);
    endfunction

    function automatic logic [3:0] rand_mask();
        logic [3:0] m;
        m = 4'($random(seed));
        return (m == '0) ? 4'b0001 : m;
    endfunction

    function automatic logic [2:0] rand_funct3();
        logic [2:0] f;
        f = 3'($unsigned($random(seed)) % 6);
        return (f < 3) ? f + 3'd1 : f + 3'd2; // skips 000 and 100
    endfunction

    function automatic logic [31:0] lane_value(input logic [11:0] addr, input logic [1:0] warp,
                                               input int lane);
        logic [31:0] v;
        case (addr)
            CSR_SCRATCH0, CSR_SCRATCH1, CSR_SCRATCH2, CSR_SCRATCH3: v = model[warp][addr[1:0]];
            CSR_LTID:    v = 32'(lane);
            CSR_GTID:    v = 32'(warp) * NUM_THREADS + 32'(lane);
            CSR_WARP_ID: v = 32'(warp);
            CSR_INSTRET: v = 32'(retire_count);
            default:     v = '0; // core id is 0 on this core
        endcase
        return v;
    endfunction

    // expected writeback is worked out when upstream sees the instruction taken
    task automatic record(input logic [3:0] mask, input logic [1:0] warp,
                          input logic [31:0] word, input logic [31:0] data);
        expect_t              e;
        logic [2:0]           funct3;
        logic [11:0]          addr;
        logic [DATA_BITS-1:0] src;
        logic [DATA_BITS-1:0] old;
        funct3 = word[14:12];
        addr   = word[31:20];
        src    = funct3[2] ? 32'(word[19:15]) : data;
        if (is_csr_word(word) && mask != '0) begin
            e.wb.valid    = mask;
            e.wb.warp_num = warp;
            e.wb.rd       = word[11:7];
            e.wb.wb       = (word[11:7] != 5'd0);
            e.is_cycle    = (addr == CSR_CYCLE);
            for (int i = 0; i < NUM_THREADS; i++) begin
                e.wb.data[i] = lane_value(addr, warp, i);
            end
            exp_q.push_back(e);
            if (addr[11:2] == CSR_SCRATCH0[11:2]) begin
                old = model[warp][addr[1:0]];
                case (funct3[1:0])
                    2'b01:   model[warp][addr[1:0]] = src;
                    2'b10:   model[warp][addr[1:0]] = old | src;
                    default: model[warp][addr[1:0]] = old & ~src;
                endcase
            end
        end
    endtask

    // a writeback counts once, on the edge where the stage hands over
    task automatic check_wb();
        expect_t e;
        if (wb_out.valid != '0 && !no_slot) begin
            if (exp_q.size() == 0) begin
                abort_run("writeback valid with no CSR instruction in flight");
            end else begin
                e = exp_q.pop_front();
                check_value("wb_out.valid", 32'(e.wb.valid), 32'(wb_out.valid));
                check_value("wb_out.warp_num", 32'(e.wb.warp_num), 32'(wb_out.warp_num));
                check_value("wb_out.rd", 32'(e.wb.rd), 32'(wb_out.rd));
                check_value("wb_out.wb", 32'(e.wb.wb), 32'(wb_out.wb));
                for (int i = 0; i < NUM_THREADS; i++) begin
                    if (e.wb.valid[i] && e.is_cycle) begin
                        assert (wb_out.data[i] > last_cycle) else begin
                            $display("FAILED at %0t ns: %s expected above %h, actual %h", $time,
                                     $sformatf("wb_out.data[%0d]", i), last_cycle,
                                     wb_out.data[i]);
                            $display("Simulation failed");
                            $fatal(1);
                        end
                    end else if (e.wb.valid[i]) begin
                        check_value($sformatf("wb_out.data[%0d]", i), e.wb.data[i], wb_out.data[i]);
                    end
                end
                if (e.is_cycle) last_cycle = wb_out.data[0];
            end
        end
    endtask

    // decode loads whatever is on the inputs on every edge where stall is low
    task automatic check_stall();
        check_value("stall", 32'(no_slot && csr_pending), 32'(stall));
        if (!(no_slot && csr_pending)) begin
            csr_pending = (instr_valid != '0) && is_csr_word(instr);
        end
    endtask

    // upstream keeps the same instruction on its inputs until stall drops
    task automatic send(input logic [3:0] mask, input logic [1:0] warp,
                        input logic [31:0] word, input logic [31:0] data);
        bit taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            no_slot     = bp_on ? 1'($random(seed)) : 1'b0;
            retire      = 1'b0;
            instr_valid = mask;
            instr_warp  = warp;
            instr       = word;
            rs1_data    = data;
            #1;
            check_wb();
            check_stall();
            taken = !stall;
        end
        record(mask, warp, word, data);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            no_slot     = bp_on ? 1'($random(seed)) : 1'b0;
            retire      = 1'b0;
            instr_valid = '0;
            #1;
            check_wb();
            check_stall();
        end
    endtask

    task automatic pulse_retire(input int k);
        repeat (k) begin
            @(negedge clk);
            no_slot     = 1'b0;
            instr_valid = '0;
            retire      = 1'b1;
            #1;
            check_wb();
            check_stall();
            retire_count++;
        end
        idle_cycles(1);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            idle_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0) abort_run("an expected writeback never appeared");
    endtask

    always @(negedge clk) begin
        if (dut.u_assert.fail_count != 0) begin
            abort_run("a concurrent assertion on csr_unit failed");
        end
    end

    initial begin
        #((NUM_INSTR * 20 + RESET_CYCLES) * CLK_PERIOD);
        abort_run("watchdog timeout before the tests completed");
    end

    initial begin
        logic [1:0]  warp;
        logic [11:0] addr;
        logic [31:0] word;
        arst_n      = 1'b0;
        instr_valid = '0;
        instr_warp  = '0;
        instr       = '0;
        rs1_data    = '0;
        no_slot     = 1'b0;
        retire      = 1'b0;
        foreach (model[w, s]) model[w][s] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int s = 0; s < NUM_SCRATCH; s++) begin
                send(rand_mask(), 2'(w), csr_instr(CSR_SCRATCH0 + 12'(s), 5'd0, 3'b001,
                     5'($random(seed))), $random(seed));
            end
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int s = 0; s < NUM_SCRATCH; s++) begin
                send(rand_mask(), 2'(w), csr_instr(CSR_SCRATCH0 + 12'(s), 5'd0, 3'b110, 5'd7), '0);
            end
        end
        drain();

        // same register and warp back to back, so each op reads the one before
        repeat (4) begin
            warp = 2'($random(seed));
            addr = CSR_SCRATCH0 + 12'($random(seed) & 3);
            repeat (6) begin
                send(rand_mask(), warp, csr_instr(addr, 5'($random(seed)), rand_funct3(),
                     5'($random(seed))), $random(seed));
            end
        end
        drain();

        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int a = 0; a < 4; a++) begin
                send(rand_mask(), 2'(w), csr_instr(RO_ADDR[a], 5'd0, 3'b110, 5'(a + 1)), '0);
            end
        end
        for (int a = 0; a < 4; a++) begin
            send(rand_mask(), 2'd2, csr_instr(RO_ADDR[a], 5'd0, 3'b001, 5'd3), $random(seed));
            send(rand_mask(), 2'd2, csr_instr(RO_ADDR[a], 5'd0, 3'b110, 5'd4), '0);
        end
        drain();

        repeat (3) send(4'hF, 2'd0, csr_instr(CSR_CYCLE, 5'd0, 3'b010, 5'd5), '0);
        send(4'hF, 2'd0, csr_instr(CSR_INSTRET, 5'd0, 3'b010, 5'd6), '0);
        drain();
        send(4'hF, 2'd1, csr_instr(CSR_INSTRET, 5'd0, 3'b010, 5'd6), '0);
        drain();
        pulse_retire(5);
        send(4'hF, 2'd3, csr_instr(CSR_INSTRET, 5'd0, 3'b010, 5'd6), '0);
        drain();

        bp_on = 1'b1;
        repeat (40) begin
            addr = (($random(seed) & 7) == 0) ? CSR_GTID : CSR_SCRATCH0 + 12'($random(seed) & 3);
            send(rand_mask(), 2'($random(seed)), csr_instr(addr, 5'($random(seed)),
                 rand_funct3(), 5'($random(seed))), $random(seed));
        end
        drain();
        bp_on = 1'b0;

        // pipeline is empty here, so any writeback from these is an error
        repeat (8) begin
            word = $random(seed);
            if (word[6:0] == SYSTEM_OPCODE) word[2] = 1'b1;
            send(rand_mask(), 2'($random(seed)), word, $random(seed));
        end
        idle_cycles(4);

        if (exp_q.size() == 0 && dut.u_assert.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("writebacks missing or an assertion failed at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- dv/csr_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assert (
    input wire                   clk,
    input wire                   arst_n,
    input wire                   no_slot,
    input wire                   stall,
    input wire csr_pkg::csr_wb_t wb_out
);

    int fail_count = 0; // read by the testbench

    valid_in_reset: assert property (@(posedge clk) !arst_n |-> (wb_out.valid == '0))
        else begin
            $error("writeback valid mask is not zero during reset");
            fail_count++;
        end

    stall_needs_no_slot: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> no_slot)
        else begin
            $error("stall is high without no_slot");
            fail_count++;
        end

    wb_held: assert property (@(posedge clk) disable iff (!arst_n)
        no_slot |=> $stable(wb_out))
        else begin
            $error("wb_out changed while no_slot was high");
            fail_count++;
        end

endmodule

bind csr_unit csr_unit_assert u_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .no_slot (no_slot),
    .stall   (stall),
    .wb_out  (wb_out)
);

`default_nettype wire

//--- src/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire [csr_pkg::NUM_THREADS-1:0] instr_valid,
    input  wire [csr_pkg::NW_BITS-1:0]     instr_warp,
    input  wire [31:0]                     instr,
    input  wire [csr_pkg::DATA_BITS-1:0]   rs1_data,
    input  wire                            no_slot,
    input  wire                            retire,
    output logic                           stall,
    output csr_pkg::csr_wb_t               wb_out
);

    import csr_pkg::*;

    csr_req_t   req;
    csr_stage_t stage;

    csr_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .hold        (no_slot),
        .instr_valid (instr_valid),
        .instr_warp  (instr_warp),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .req         (req)
    );

    csr_pipe u_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .no_slot (no_slot),
        .req     (req),
        .retire  (retire),
        .stage   (stage),
        .stall   (stall)
    );

    csr_result u_result (
        .stage  (stage),
        .wb_out (wb_out)
    );

endmodule

`default_nettype wire

//--- src/csr_result.sv
`timescale 1ns/1ps
`default_nettype none

module csr_result (
    input  wire csr_pkg::csr_stage_t stage,
    output csr_pkg::csr_wb_t         wb_out
);

    import csr_pkg::*;

    always_comb begin
        wb_out.valid    = stage.valid;
        wb_out.warp_num = stage.warp_num;
        wb_out.rd       = stage.rd;
        wb_out.wb       = stage.wb;
        for (int i = 0; i < NUM_THREADS; i++) begin
            if (stage.addr == CSR_LTID) begin
                wb_out.data[i] = DATA_BITS'(i);
            end else if (stage.addr == CSR_GTID) begin
                // read value is the warp number here
                wb_out.data[i] = DATA_BITS'(stage.read_data * NUM_THREADS + i);
            end else begin
                wb_out.data[i] = stage.read_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/csr_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module csr_pipe (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    no_slot,
    input  wire csr_pkg::csr_req_t req,
    input  wire                    retire,
    output csr_pkg::csr_stage_t    stage,
    output logic                   stall
);

    import csr_pkg::*;

    logic [DATA_BITS-1:0] file_data;
    logic [DATA_BITS-1:0] read_data;
    logic [DATA_BITS-1:0] updated_data;
    logic                 fwd_hit;
    logic                 write_en;
    logic                 file_we;
    csr_stage_t           stage_d;

    // the stage writes once, on the edge where it hands over to the next request
    assign file_we = stage.write_en && !no_slot;

    csr_file u_file (
        .clk        (clk),
        .arst_n     (arst_n),
        .read_addr  (req.addr),
        .read_warp  (req.warp_num),
        .read_data  (file_data),
        .write_en   (file_we),
        .write_addr (stage.addr),
        .write_warp (stage.warp_num),
        .write_data (stage.updated_data),
        .retire     (retire)
    );

    // the value in the second stage is newer than the file until it is written
    assign fwd_hit = stage.write_en
                  && (stage.addr == req.addr)
                  && (stage.warp_num == req.warp_num);

    assign read_data = fwd_hit ? stage.updated_data : file_data;

    always_comb begin
        case (req.op)
            CSR_OP_RW: updated_data = req.mask;
            CSR_OP_RS: updated_data = read_data | req.mask;
            CSR_OP_RC: updated_data = read_data & ~req.mask;
            default:   updated_data = read_data;
        endcase
    end

    // decode already turned the non-writing forms into a set with zero mask
    assign write_en = (|req.valid)
                   && is_scratch_addr(req.addr)
                   && !(req.op == CSR_OP_RS && req.mask == '0);

    always_comb begin
        stage_d.valid        = req.valid;
        stage_d.warp_num     = req.warp_num;
        stage_d.rd           = req.rd;
        stage_d.wb           = req.wb;
        stage_d.addr         = req.addr;
        stage_d.read_data    = read_data;
        stage_d.updated_data = updated_data;
        stage_d.write_en     = write_en;
    end

    pipe_reg #(
        .payload_t(csr_stage_t)
    ) u_stage_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (no_slot),
        .d      (stage_d),
        .q      (stage)
    );

    assign stall = no_slot && (|req.valid);

endmodule

`default_nettype wire

//--- src/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire [csr_pkg::CSR_ADDR_BITS-1:0] read_addr,
    input  wire [csr_pkg::NW_BITS-1:0]       read_warp,
    output logic [csr_pkg::DATA_BITS-1:0]    read_data,
    input  wire                              write_en,
    input  wire [csr_pkg::CSR_ADDR_BITS-1:0] write_addr,
    input  wire [csr_pkg::NW_BITS-1:0]       write_warp,
    input  wire [csr_pkg::DATA_BITS-1:0]     write_data,
    input  wire                              retire
);

    import csr_pkg::*;

    logic [NUM_WARPS-1:0][NUM_SCRATCH-1:0][DATA_BITS-1:0] scratch;
    logic [DATA_BITS-1:0] cycle_cnt;
    logic [DATA_BITS-1:0] instret_cnt;
    logic                 scratch_we;

    assign scratch_we = write_en && is_scratch_addr(write_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scratch <= '0;
        end else if (scratch_we) begin
            scratch[write_warp][write_addr[SCRATCH_BITS-1:0]] <= write_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + DATA_BITS'(1);
        end
    end

    // retire comes from the writeback side of the core, one pulse per instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instret_cnt <= '0;
        end else if (retire) begin
            instret_cnt <= instret_cnt + DATA_BITS'(1);
        end
    end

    always_comb begin
        case (read_addr)
            CSR_SCRATCH0,
            CSR_SCRATCH1,
            CSR_SCRATCH2,
            CSR_SCRATCH3: read_data = scratch[read_warp][read_addr[SCRATCH_BITS-1:0]];
            CSR_CYCLE:    read_data = cycle_cnt;
            CSR_INSTRET:  read_data = instret_cnt;
            CSR_WARP_ID:  read_data = DATA_BITS'(read_warp);
            CSR_CORE_ID:  read_data = CORE_ID;
            // the result stage turns the warp number into per-lane global ids
            CSR_GTID:     read_data = DATA_BITS'(read_warp);
            CSR_LTID:     read_data = '0; // lane index is added later
            default:      read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            hold,
    input  wire [csr_pkg::NUM_THREADS-1:0] instr_valid,
    input  wire [csr_pkg::NW_BITS-1:0]     instr_warp,
    input  wire [31:0]                     instr,
    input  wire [csr_pkg::DATA_BITS-1:0]   rs1_data,
    output csr_pkg::csr_req_t              req
);

    import csr_pkg::*;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [4:0]           rd;
    logic [4:0]           rs1;
    logic                 is_csr;
    logic                 read_only;
    logic [DATA_BITS-1:0] src;
    logic                 dec_hold;
    csr_op_e              op;
    csr_req_t             req_d;

    assign opcode    = instr[6:0];
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign read_only = (instr[31:30] == 2'b11);

    // funct3 of 000 and 100 are not CSR forms (ecall/ebreak and reserved)
    assign is_csr = (opcode == OPCODE_SYSTEM) && (funct3[1:0] != 2'b00);

    always_comb begin
        case (funct3[1:0])
            2'b10:   op = CSR_OP_RS;
            2'b11:   op = CSR_OP_RC;
            default: op = CSR_OP_RW;
        endcase
    end

    assign src = funct3[2] ? DATA_BITS'(rs1) : rs1_data; // zimm forms

    always_comb begin
        req_d          = '0;
        req_d.valid    = is_csr ? instr_valid : '0;
        req_d.warp_num = instr_warp;
        req_d.rd       = rd;
        req_d.wb       = (rd != 5'd0);
        req_d.addr     = instr[31:20];
        req_d.op       = op;
        req_d.mask     = src;
        // a set or clear of nothing, or any write to a read only CSR, becomes a plain read
        if (read_only || (op != CSR_OP_RW && src == '0)) begin
            req_d.op   = CSR_OP_RS;
            req_d.mask = '0;
        end
    end

    // an empty register can still take a new request while downstream is full
    assign dec_hold = hold && (|req.valid);

    pipe_reg #(
        .payload_t(csr_req_t)
    ) u_req_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (dec_hold),
        .d      (req_d),
        .q      (req)
    );

endmodule

`default_nettype wire

//--- src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           arst_n,
    input  wire           stall,
    input  wire payload_t d,
    output payload_t      q
);

    // the payload carries its valid mask, so clearing it all leaves a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int NUM_THREADS   = 4;  // lanes per warp
    localparam int NUM_WARPS     = 4;
    localparam int NW_BITS       = 2;
    localparam int CSR_ADDR_BITS = 12;
    localparam int DATA_BITS     = 32;
    localparam int NUM_SCRATCH   = 4;
    localparam int SCRATCH_BITS  = 2;

    localparam logic [DATA_BITS-1:0] CORE_ID = DATA_BITS'(0);

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // scratch registers sit in the custom read/write range, aligned on four
    localparam logic [CSR_ADDR_BITS-1:0] CSR_SCRATCH0 = 12'h800;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_SCRATCH1 = 12'h801;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_SCRATCH2 = 12'h802;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_SCRATCH3 = 12'h803;

    // everything with addr[11:10] == 2'b11 is read only
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CYCLE    = 12'hC00;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_INSTRET  = 12'hC02;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_LTID     = 12'hCC0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_GTID     = 12'hCC1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_WARP_ID  = 12'hCC2;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CORE_ID  = 12'hCC3;

    typedef enum logic [1:0] {
        CSR_OP_RW = 2'd0,
        CSR_OP_RS = 2'd1,
        CSR_OP_RC = 2'd2
    } csr_op_e;

    typedef struct packed {
        logic [NUM_THREADS-1:0]   valid;
        logic [NW_BITS-1:0]       warp_num;
        logic [4:0]               rd;
        logic                     wb;
        csr_op_e                  op;
        logic [CSR_ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]     mask;
    } csr_req_t;

    typedef struct packed {
        logic [NUM_THREADS-1:0]   valid;
        logic [NW_BITS-1:0]       warp_num;
        logic [4:0]               rd;
        logic                     wb;
        logic [CSR_ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]     read_data;     // value before the update
        logic [DATA_BITS-1:0]     updated_data;
        logic                     write_en;
    } csr_stage_t;

    typedef struct packed {
        logic [NUM_THREADS-1:0]                valid;
        logic [NW_BITS-1:0]                    warp_num;
        logic [4:0]                            rd;
        logic                                  wb;
        logic [NUM_THREADS-1:0][DATA_BITS-1:0] data;
    } csr_wb_t;

    function automatic logic is_scratch_addr(logic [CSR_ADDR_BITS-1:0] addr);
        return addr[CSR_ADDR_BITS-1:SCRATCH_BITS] ==
               CSR_SCRATCH0[CSR_ADDR_BITS-1:SCRATCH_BITS];
    endfunction

endpackage

`default_nettype wire
